// ==== source/cache_pkg.sv ====
package cache_pkg;

    // One data word, also used for byte and line addresses
    typedef logic [31:0] word_t;

    // Four words, word i in bits 32*i and up
    typedef logic [127:0] line_t;

    // RISC-V funct3 access size
    typedef logic [2:0] size_t;

    localparam size_t SIZE_BYTE = 3'b000;
    localparam size_t SIZE_HALF = 3'b001;
    localparam size_t SIZE_WORD = 3'b010;

    localparam int WORDS_PER_LINE = 4;

    // Request kind seen by the cache
    typedef enum logic [1:0] {
        OP_IDLE,
        OP_LOAD,
        OP_STORE
    } cache_op_e;

endpackage

// ==== source/line_port_if.sv ====
`timescale 1ns/1ps

interface line_port_if import cache_pkg::*; ();

    logic  wb_valid;
    word_t wb_addr;     // Line address, byte address >> 4
    line_t wb_data;
    logic  wb_room;
    word_t fetch_addr;  // Line address as well
    line_t fetch_data;

    // Side that evicts lines and asks for fills
    modport upstream (
        output wb_valid, wb_addr, wb_data, fetch_addr,
        input  wb_room, fetch_data
    );

    // Side that absorbs lines and answers fills
    modport downstream (
        input  wb_valid, wb_addr, wb_data, fetch_addr,
        output wb_room, fetch_data
    );

endinterface

// ==== source/data_cache.sv ====
`timescale 1ns/1ps

module data_cache import cache_pkg::*; #(
    parameter int NUM_SETS = 4
) (
    input  logic          clk,
    input  logic          rst,
    input  logic          rd_en,
    input  logic          wr_en,
    input  word_t         addr,
    input  word_t         write_data,
    input  size_t         funct3,
    output word_t         read_data,
    output logic          hit,
    output logic          resp_valid,
    output logic          busy,
    line_port_if.upstream mem
);

    localparam int IDX_W = $clog2(NUM_SETS);
    localparam int TAG_W = 28 - IDX_W;  // Line address minus index

    logic [TAG_W-1:0]    tag_array [NUM_SETS];
    line_t               data_array [NUM_SETS];
    logic [NUM_SETS-1:0] valid;
    logic [NUM_SETS-1:0] dirty;

    logic [TAG_W-1:0] tag;
    logic [IDX_W-1:0] index;
    logic [1:0]       word_off;
    logic [1:0]       lane;

    cache_op_e  op;
    logic       lookup_hit;
    line_t      cur_line;
    line_t      store_line;
    word_t      sel_word;
    word_t      lane_word;
    word_t      wdata_rep;
    word_t      merged_word;
    word_t      load_word;
    logic [3:0] byte_en;

    // Address split
    assign tag      = addr[31 -: TAG_W];
    assign index    = addr[4 +: IDX_W];
    assign word_off = addr[3:2];
    assign lane     = addr[1:0];

    assign busy = !mem.wb_room;

    // Store wins when both strobes are high
    always_comb begin
        if (busy) begin
            op = OP_IDLE;
        end else if (wr_en) begin
            op = OP_STORE;
        end else if (rd_en) begin
            op = OP_LOAD;
        end else begin
            op = OP_IDLE;
        end
    end

    assign lookup_hit = valid[index] && (tag_array[index] == tag);

    // On a miss the fetched line stands in for the cached one
    assign cur_line = lookup_hit ? data_array[index] : mem.fetch_data;
    assign sel_word = cur_line[32*word_off +: 32];

    assign mem.fetch_addr = {4'b0000, tag, index};

    // Victim goes out on the same edge the new line is filled
    assign mem.wb_valid = (op != OP_IDLE) && !lookup_hit && valid[index] && dirty[index];
    assign mem.wb_addr  = {4'b0000, tag_array[index], index};
    assign mem.wb_data  = data_array[index];

    // Zero-extended load formatting
    always_comb begin
        lane_word = sel_word >> {lane, 3'b000};
        case (funct3)
            SIZE_BYTE: load_word = {24'b0, lane_word[7:0]};
            SIZE_HALF: load_word = {16'b0, lane_word[15:0]};
            default:   load_word = sel_word;
        endcase
    end

    // Store merge into the selected word
    always_comb begin
        case (funct3)
            SIZE_BYTE: begin
                wdata_rep = {4{write_data[7:0]}};
                byte_en   = 4'b0001 << lane;
            end
            SIZE_HALF: begin
                wdata_rep = {2{write_data[15:0]}};
                byte_en   = lane[1] ? 4'b1100 : 4'b0011;  // Half-word aligned
            end
            default: begin
                wdata_rep = write_data;
                byte_en   = 4'b1111;
            end
        endcase
        for (int b = 0; b < 4; b++) begin
            merged_word[8*b +: 8] = byte_en[b] ? wdata_rep[8*b +: 8] : sel_word[8*b +: 8];
        end
        store_line = cur_line;
        store_line[32*word_off +: 32] = merged_word;
    end

    // Control state
    always_ff @(posedge clk) begin
        if (rst) begin
            valid      <= '0;
            dirty      <= '0;
            resp_valid <= 1'b0;
            hit        <= 1'b0;
        end else begin
            resp_valid <= (op != OP_IDLE);
            hit        <= (op != OP_IDLE) && lookup_hit;
            if (op != OP_IDLE) begin
                valid[index] <= 1'b1;
                if (op == OP_STORE) begin
                    dirty[index] <= 1'b1;
                end else if (!lookup_hit) begin
                    dirty[index] <= 1'b0;  // Clean fill
                end
            end
        end
    end

    // Tags, data and load result
    always_ff @(posedge clk) begin
        if (op == OP_LOAD) begin
            read_data <= load_word;
        end
        if (op != OP_IDLE) begin
            tag_array[index]  <= tag;
            data_array[index] <= (op == OP_STORE) ? store_line : cur_line;
        end
    end

endmodule

// ==== source/writeback_buffer.sv ====
`timescale 1ns/1ps

module writeback_buffer import cache_pkg::*; #(
    parameter int WB_DEPTH = 2
) (
    input  logic            clk,
    input  logic            rst,
    line_port_if.downstream cache_side,
    line_port_if.upstream   mem_side
);

    localparam int PTR_W = (WB_DEPTH > 1) ? $clog2(WB_DEPTH) : 1;
    localparam int CNT_W = $clog2(WB_DEPTH + 1);

    word_t addr_q [WB_DEPTH];
    line_t data_q [WB_DEPTH];

    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;

    logic  push;
    logic  pop;
    line_t fwd_line;

    function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] p);
        return (int'(p) == WB_DEPTH - 1) ? '0 : p + 1'b1;
    endfunction

    assign cache_side.wb_room = (count != CNT_W'(WB_DEPTH));

    assign push = cache_side.wb_valid && cache_side.wb_room;
    assign pop  = mem_side.wb_valid && mem_side.wb_room;

    // Oldest line is always on offer to memory
    assign mem_side.wb_valid = (count != '0);
    assign mem_side.wb_addr  = addr_q[rd_ptr];
    assign mem_side.wb_data  = data_q[rd_ptr];

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= next_ptr(wr_ptr);
            end
            if (pop) begin
                rd_ptr <= next_ptr(rd_ptr);
            end
            count <= count + CNT_W'(push) - CNT_W'(pop);
        end
    end

    always_ff @(posedge clk) begin
        if (push) begin
            addr_q[wr_ptr] <= cache_side.wb_addr;
            data_q[wr_ptr] <= cache_side.wb_data;
        end
    end

    // Fetch forwarding, scan oldest to youngest so the last match wins
    assign mem_side.fetch_addr = cache_side.fetch_addr;

    always_comb begin
        int slot;
        fwd_line = mem_side.fetch_data;  // Memory copy unless a pending line matches
        for (int i = 0; i < WB_DEPTH; i++) begin
            slot = (int'(rd_ptr) + i) % WB_DEPTH;
            if (i < int'(count) && addr_q[slot] == cache_side.fetch_addr) begin
                fwd_line = data_q[slot];
            end
        end
    end

    assign cache_side.fetch_data = fwd_line;

endmodule

// ==== source/backing_memory.sv ====
`timescale 1ns/1ps

module backing_memory import cache_pkg::*; #(
    parameter int MEM_LINES    = 64,
    parameter int WRITE_CYCLES = 4
) (
    input  logic            clk,
    input  logic            rst,
    line_port_if.downstream port
);

    localparam int IDX_W = (MEM_LINES > 1) ? $clog2(MEM_LINES) : 1;
    localparam int CNT_W = (WRITE_CYCLES > 0) ? $clog2(WRITE_CYCLES + 1) : 1;

    line_t mem [MEM_LINES];

    logic [IDX_W-1:0] fetch_idx;
    logic [IDX_W-1:0] wr_idx;
    logic [CNT_W-1:0] wait_cnt;
    logic             accept;

    // Known startup pattern, each word is its byte address XOR A5A50000
    initial begin
        for (int l = 0; l < MEM_LINES; l++) begin
            for (int w = 0; w < WORDS_PER_LINE; w++) begin
                mem[l][32*w +: 32] = word_t'(16*l + 4*w) ^ 32'hA5A50000;
            end
        end
    end

    // Line address wraps onto the array
    assign fetch_idx = IDX_W'(port.fetch_addr % MEM_LINES);
    assign wr_idx    = IDX_W'(port.wb_addr % MEM_LINES);

    assign port.fetch_data = mem[fetch_idx];  // Combinational read

    assign port.wb_room = (wait_cnt == '0);
    assign accept       = port.wb_valid && port.wb_room;

    always_ff @(posedge clk) begin
        if (accept) begin
            mem[wr_idx] <= port.wb_data;
        end
    end

    // Slow write port, room stays low for WRITE_CYCLES after each line
    always_ff @(posedge clk) begin
        if (rst) begin
            wait_cnt <= '0;
        end else if (accept) begin
            wait_cnt <= CNT_W'(WRITE_CYCLES);
        end else if (wait_cnt != '0) begin
            wait_cnt <= wait_cnt - 1'b1;
        end
    end

endmodule

// ==== source/cache_subsystem.sv ====
`timescale 1ns/1ps

module cache_subsystem import cache_pkg::*; #(
    parameter int NUM_SETS     = 4,
    parameter int WB_DEPTH     = 2,
    parameter int MEM_LINES    = 64,
    parameter int WRITE_CYCLES = 4
) (
    input  logic  clk,
    input  logic  rst,
    input  logic  rd_en,
    input  logic  wr_en,
    input  word_t addr,
    input  word_t write_data,
    input  size_t funct3,
    output word_t read_data,
    output logic  hit,
    output logic  resp_valid,
    output logic  busy
);

    line_port_if cache_port ();  // Cache to write-back buffer
    line_port_if mem_port ();    // Write-back buffer to memory

    data_cache #(
        .NUM_SETS (NUM_SETS)
    ) u_data_cache (
        .clk        (clk),
        .rst        (rst),
        .rd_en      (rd_en),
        .wr_en      (wr_en),
        .addr       (addr),
        .write_data (write_data),
        .funct3     (funct3),
        .read_data  (read_data),
        .hit        (hit),
        .resp_valid (resp_valid),
        .busy       (busy),
        .mem        (cache_port)
    );

    writeback_buffer #(
        .WB_DEPTH (WB_DEPTH)
    ) u_writeback_buffer (
        .clk        (clk),
        .rst        (rst),
        .cache_side (cache_port),
        .mem_side   (mem_port)
    );

    backing_memory #(
        .MEM_LINES    (MEM_LINES),
        .WRITE_CYCLES (WRITE_CYCLES)
    ) u_backing_memory (
        .clk  (clk),
        .rst  (rst),
        .port (mem_port)
    );

endmodule

// ==== bench/cache_subsystem_props.sv ====
`timescale 1ns/1ps

module cache_subsystem_props (
    input logic clk,
    input logic rst,
    input logic rd_en,
    input logic wr_en,
    input logic busy,
    input logic resp_valid,
    input logic hit
);

    logic accepted;

    assign accepted = (rd_en || wr_en) && !busy;  // Requests while busy are ignored

    resp_follows_strobe: assert property (
        @(posedge clk) disable iff (rst) accepted |=> resp_valid
    ) else $error("resp_valid missing one cycle after an accepted strobe");

    // No response without a request the cycle before
    resp_needs_strobe: assert property (
        @(posedge clk) disable iff (rst) !accepted |=> !resp_valid
    ) else $error("resp_valid without a preceding accepted strobe");

    quiet_after_reset: assert property (
        @(posedge clk) rst |=> !resp_valid && !hit && !busy
    ) else $error("resp_valid, hit or busy high in the cycle after reset");

endmodule

bind cache_subsystem cache_subsystem_props props_i (
    .clk        (clk),
    .rst        (rst),
    .rd_en      (rd_en),
    .wr_en      (wr_en),
    .busy       (busy),
    .resp_valid (resp_valid),
    .hit        (hit)
);

// ==== bench/cache_subsystem_tb.sv ====
`timescale 1ns/1ps

module cache_subsystem_tb import cache_pkg::*; ();

    localparam int NUM_SETS     = 4;
    localparam int WB_DEPTH     = 2;
    localparam int MEM_LINES    = 64;
    localparam int WRITE_CYCLES = 4;
    localparam int RAND_COUNT   = 200;
    localparam int REQ_CYCLES   = WB_DEPTH * (WRITE_CYCLES + 1) + 3;  // Worst case per request
    localparam int SET_W        = $clog2(NUM_SETS);
    localparam int LINE_W       = $clog2(MEM_LINES);
    localparam int WADDR_W      = $clog2(MEM_LINES * WORDS_PER_LINE);

    typedef struct packed {
        cache_op_e op;
        size_t     f3;
        word_t     addr;
        word_t     wdata;
        logic      hit;
        word_t     rdata;
    } entry_t;

    logic  clk;
    logic  rst;
    logic  rd_en;
    logic  wr_en;
    word_t addr;
    word_t write_data;
    size_t funct3;
    word_t read_data;
    logic  hit;
    logic  resp_valid;
    logic  busy;

    entry_t stim_table [$];
    word_t  shadow_mem [MEM_LINES * WORDS_PER_LINE];  // Coherent view of every word
    word_t  shadow_line [NUM_SETS];
    logic   shadow_valid [NUM_SETS];
    word_t  lfsr;
    logic   saw_busy;
    int     cycle_count = 0;
    int     cycle_limit = 0;

    cache_subsystem #(
        .NUM_SETS     (NUM_SETS),
        .WB_DEPTH     (WB_DEPTH),
        .MEM_LINES    (MEM_LINES),
        .WRITE_CYCLES (WRITE_CYCLES)
    ) dut_i (
        .clk        (clk),
        .rst        (rst),
        .rd_en      (rd_en),
        .wr_en      (wr_en),
        .addr       (addr),
        .write_data (write_data),
        .funct3     (funct3),
        .read_data  (read_data),
        .hit        (hit),
        .resp_valid (resp_valid),
        .busy       (busy)
    );

    always #5 clk = ~clk;

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_limit > 0 && cycle_count >= cycle_limit) begin
            $display("Timeout: run still going after %0d cycles", cycle_count);
            abort_run();
        end
    end

    task automatic abort_run();
        $display("TESTBENCH FAILED");
        $fatal(1, "stopped at first error");
    endtask

    task automatic check_word(input string name, input word_t got, input word_t exp);
        if (got !== exp) begin
            $display("Error at %0t: %s is %h, expected %h", $time, name, got, exp);
            abort_run();
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("Error at %0t: %s is %b, expected %b", $time, name, got, exp);
            abort_run();
        end
    endtask

    // Fibonacci LFSR, taps 32 22 2 1, one step per bit
    function automatic word_t rand_bits(input int n);
        word_t v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = {lfsr[30:0], lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0]};
            v    = {v[30:0], lfsr[0]};
        end
        return v;
    endfunction

    function automatic word_t pattern_word(input word_t a);
        return {a[31:2], 2'b00} ^ 32'hA5A50000;
    endfunction

    // Zero-extended lane of a word
    function automatic word_t lane_load(input word_t w, input size_t f3, input logic [1:0] lane);
        word_t s;
        s = w >> (8 * lane);
        case (f3)
            SIZE_BYTE: return {24'h0, s[7:0]};
            SIZE_HALF: return {16'h0, s[15:0]};
            default:   return w;
        endcase
    endfunction

    function automatic word_t lane_store(input word_t old, input word_t wd, input size_t f3,
                                         input logic [1:0] lane);
        word_t r;
        r = old;
        case (f3)
            SIZE_BYTE: r[8*lane +: 8] = wd[7:0];
            SIZE_HALF: r[16*lane[1] +: 16] = wd[15:0];
            default:   r = wd;
        endcase
        return r;
    endfunction

    function automatic logic predict_hit(input word_t a);
        return shadow_valid[a[4 +: SET_W]] && (shadow_line[a[4 +: SET_W]] == (a >> 4));
    endfunction

    task automatic update_shadow(input cache_op_e op, input size_t f3, input word_t a,
                                 input word_t wd);
        shadow_valid[a[4 +: SET_W]] = 1'b1;
        shadow_line[a[4 +: SET_W]]  = a >> 4;
        if (op == OP_STORE) begin
            shadow_mem[a[2 +: WADDR_W]] = lane_store(shadow_mem[a[2 +: WADDR_W]], wd, f3, a[1:0]);
        end
    endtask

    task automatic add_entry(input cache_op_e op, input size_t f3, input word_t a,
                             input word_t wd, input logic h, input word_t rd);
        stim_table.push_back('{op, f3, a, wd, h, rd});
    endtask

    // Starts and ends at a falling edge
    task automatic do_request(input cache_op_e op, input size_t f3, input word_t a,
                              input word_t wd, input logic exp_hit, input word_t exp_rd);
        while (busy) begin
            saw_busy = 1'b1;
            @(negedge clk);
        end
        @(posedge clk);
        rd_en      <= (op == OP_LOAD);
        wr_en      <= (op == OP_STORE);
        addr       <= a;
        write_data <= wd;
        funct3     <= f3;
        @(posedge clk);
        rd_en <= 1'b0;
        wr_en <= 1'b0;
        @(negedge clk);
        if (!resp_valid) begin
            $display("Request to address %h got no resp_valid pulse", a);
            abort_run();
        end
        check_bit("hit", hit, exp_hit);
        if (op == OP_LOAD) begin
            check_word("read_data", read_data, exp_rd);
        end
        update_shadow(op, f3, a, wd);
    endtask

    task automatic build_table();
        // Cold misses per size, then hits on every lane
        add_entry(OP_LOAD,  SIZE_WORD, 32'h100, 32'h0,        1'b0, 32'hA5A50100);
        add_entry(OP_LOAD,  SIZE_WORD, 32'h100, 32'h0,        1'b1, 32'hA5A50100);
        add_entry(OP_LOAD,  SIZE_HALF, 32'h116, 32'h0,        1'b0, 32'h0000A5A5);
        add_entry(OP_LOAD,  SIZE_HALF, 32'h114, 32'h0,        1'b1, 32'h00000114);
        add_entry(OP_LOAD,  SIZE_BYTE, 32'h123, 32'h0,        1'b0, 32'h000000A5);
        add_entry(OP_LOAD,  SIZE_BYTE, 32'h122, 32'h0,        1'b1, 32'h000000A5);
        add_entry(OP_LOAD,  SIZE_BYTE, 32'h121, 32'h0,        1'b1, 32'h00000001);
        add_entry(OP_LOAD,  SIZE_BYTE, 32'h120, 32'h0,        1'b1, 32'h00000020);
        // Store hits merge only their own bytes
        add_entry(OP_STORE, SIZE_BYTE, 32'h101, 32'h11223344, 1'b1, 32'h0);
        add_entry(OP_STORE, SIZE_HALF, 32'h102, 32'h0000BEEF, 1'b1, 32'h0);
        add_entry(OP_LOAD,  SIZE_WORD, 32'h100, 32'h0,        1'b1, 32'hBEEF4400);
        add_entry(OP_LOAD,  SIZE_WORD, 32'h104, 32'h0,        1'b1, 32'hA5A50104);
        add_entry(OP_STORE, SIZE_WORD, 32'h114, 32'hCAFEF00D, 1'b1, 32'h0);
        add_entry(OP_LOAD,  SIZE_WORD, 32'h114, 32'h0,        1'b1, 32'hCAFEF00D);
        add_entry(OP_STORE, SIZE_BYTE, 32'h123, 32'h00000077, 1'b1, 32'h0);
        add_entry(OP_LOAD,  SIZE_HALF, 32'h122, 32'h0,        1'b1, 32'h000077A5);
        // Store miss allocates the whole line
        add_entry(OP_STORE, SIZE_HALF, 32'h13A, 32'h00001234, 1'b0, 32'h0);
        add_entry(OP_LOAD,  SIZE_WORD, 32'h134, 32'h0,        1'b1, 32'hA5A50134);
        add_entry(OP_LOAD,  SIZE_WORD, 32'h138, 32'h0,        1'b1, 32'h12340138);
        // Four dirty victims back to back
        add_entry(OP_LOAD,  SIZE_WORD, 32'h140, 32'h0,        1'b0, 32'hA5A50140);
        add_entry(OP_LOAD,  SIZE_WORD, 32'h154, 32'h0,        1'b0, 32'hA5A50154);
        add_entry(OP_LOAD,  SIZE_WORD, 32'h168, 32'h0,        1'b0, 32'hA5A50168);
        add_entry(OP_LOAD,  SIZE_WORD, 32'h17C, 32'h0,        1'b0, 32'hA5A5017C);
        // Reloads, youngest victim first while it still sits in the buffer
        add_entry(OP_LOAD,  SIZE_WORD, 32'h138, 32'h0,        1'b0, 32'h12340138);
        add_entry(OP_LOAD,  SIZE_WORD, 32'h120, 32'h0,        1'b0, 32'h77A50120);
        add_entry(OP_LOAD,  SIZE_WORD, 32'h114, 32'h0,        1'b0, 32'hCAFEF00D);
        add_entry(OP_LOAD,  SIZE_WORD, 32'h100, 32'h0,        1'b0, 32'hBEEF4400);
        add_entry(OP_LOAD,  SIZE_HALF, 32'h102, 32'h0,        1'b1, 32'h0000BEEF);
    endtask

    initial begin
        cache_op_e op;
        size_t     f3;
        word_t     a, sz, lane, wd;
        clk        = 1'b0;
        rst        = 1'b1;
        rd_en      = 1'b0;
        wr_en      = 1'b0;
        addr       = '0;
        write_data = '0;
        funct3     = SIZE_WORD;
        lfsr       = 32'h48e9;
        saw_busy   = 1'b0;
        for (int i = 0; i < MEM_LINES * WORDS_PER_LINE; i++) begin
            shadow_mem[i] = pattern_word(word_t'(4 * i));
        end
        for (int s = 0; s < NUM_SETS; s++) begin
            shadow_valid[s] = 1'b0;
            shadow_line[s]  = '0;
        end
        build_table();
        cycle_limit = (stim_table.size() + RAND_COUNT) * REQ_CYCLES + 20;

        repeat (5) @(posedge clk);
        rst <= 1'b0;
        @(negedge clk);

        foreach (stim_table[i]) begin
            do_request(stim_table[i].op, stim_table[i].f3, stim_table[i].addr,
                       stim_table[i].wdata, stim_table[i].hit, stim_table[i].rdata);
        end
        check_bit("busy", saw_busy, 1'b1);  // Write-back buffer must have filled

        // Mixed random traffic against the shadow model
        for (int n = 0; n < RAND_COUNT; n++) begin
            op = (rand_bits(1) == 32'd1) ? OP_STORE : OP_LOAD;
            sz = rand_bits(2);
            a  = (rand_bits(LINE_W) << 4) | (rand_bits(2) << 2);
            if (sz == 32'd0) begin
                f3   = SIZE_BYTE;
                lane = rand_bits(2);
            end else if (sz == 32'd1) begin
                f3   = SIZE_HALF;
                lane = rand_bits(1) << 1;
            end else begin
                f3   = SIZE_WORD;
                lane = '0;
            end
            a  = a | lane;
            wd = rand_bits(32);
            do_request(op, f3, a, wd, predict_hit(a),
                       lane_load(shadow_mem[a[2 +: WADDR_W]], f3, a[1:0]));
        end

        $display("TESTBENCH PASSED");
        $finish;
    end

endmodule

// ==== project.f ====
source/cache_pkg.sv
source/line_port_if.sv
source/data_cache.sv
source/writeback_buffer.sv
source/backing_memory.sv
source/cache_subsystem.sv
bench/cache_subsystem_props.sv
bench/cache_subsystem_tb.sv

// ==== Makefile ====
# Verilator build and run of the cache subsystem testbench

VERILATOR ?= verilator
TOP       ?= cache_subsystem_tb
FILELIST  ?= project.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal

SOURCES := $(wildcard source/*.sv bench/*.sv)
SIM_BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the simulation, check $(LOG)"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "  help   show this list"
	@echo "Variables: VERILATOR TOP FILELIST BUILD_DIR LOG VFLAGS"

$(SIM_BIN): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

test: $(SIM_BIN)
	./$(SIM_BIN) 2>&1 | tee $(LOG)
	@if grep -q "TESTBENCH PASSED" $(LOG); then \
		echo "Simulation passed"; \
	else \
		echo "Simulation failed, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
